// File: bench/tb_rename_top.sv
module tb_rename_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD = 40;
  localparam int RW = width_pkg::RENAME_WIDTH;
  localparam int FW = width_pkg::FREE_WIDTH;
  localparam int PW = regfile_pkg::PREG_BITS;
  localparam int AW = regfile_pkg::AREG_BITS;
  localparam int NA = regfile_pkg::NUM_ARCH_REGS;

  logic                  clk;
  logic                  rst;
  logic [RW-1:0]         slot_valid;
  logic [RW-1:0]         dest_valid;
  logic [RW-1:0][AW-1:0] dest_arch;
  logic [RW-1:0][AW-1:0] src1_arch;
  logic [RW-1:0][AW-1:0] src2_arch;
  logic [FW-1:0]         free_valid;
  logic [FW-1:0][PW-1:0] free_phys;
  logic [RW-1:0][PW-1:0] dest_phys;
  logic [RW-1:0][PW-1:0] old_phys;
  logic [RW-1:0][PW-1:0] src1_phys;
  logic [RW-1:0][PW-1:0] src2_phys;
  logic                  stall;

  // Model state
  logic [PW-1:0] m_map [NA];    // Architectural to physical
  logic [PW-1:0] m_free [$];    // Free queue, head first
  logic [PW-1:0] retire_q [$];  // Allocated registers that are safe to free
  logic [RW-1:0][PW-1:0] e_dest;
  logic [RW-1:0][PW-1:0] e_old;
  logic [RW-1:0][PW-1:0] e_src1;
  logic [RW-1:0][PW-1:0] e_src2;
  logic          e_stall;
  logic          check_en;       // Compare process active
  logic          last_accepted;  // Group taken at the last edge
  int            err_cnt;
  int            pass_cnt;
  int            err_base;
  int            test_num;
  int            cycles;
  integer        seed;

  rename_top uut (
    .clk        (clk),
    .rst        (rst),
    .slot_valid (slot_valid),
    .dest_valid (dest_valid),
    .dest_arch  (dest_arch),
    .src1_arch  (src1_arch),
    .src2_arch  (src2_arch),
    .free_valid (free_valid),
    .free_phys  (free_phys),
    .dest_phys  (dest_phys),
    .old_phys   (old_phys),
    .src1_phys  (src1_phys),
    .src2_phys  (src2_phys),
    .stall      (stall)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Reference rename of one group
  // Walks the slots in program order over a working copy of the map
  function automatic void model_rename(
    input  logic [RW-1:0]         sv,
    input  logic [RW-1:0]         dv,
    input  logic [RW-1:0][AW-1:0] da,
    input  logic [RW-1:0][AW-1:0] s1,
    input  logic [RW-1:0][AW-1:0] s2,
    input  logic [PW-1:0]         map [NA],
    input  logic [PW-1:0]         fq [$],
    output logic [RW-1:0][PW-1:0] x_dest,
    output logic [RW-1:0][PW-1:0] x_old,
    output logic [RW-1:0][PW-1:0] x_src1,
    output logic [RW-1:0][PW-1:0] x_src2,
    output logic                  x_stall
  );
    logic [PW-1:0] cur [NA];
    int            k;
    cur = map;
    k = 0;
    x_stall = (fq.size() < RW);  // Whole group waits for four free
    for (int i = 0; i < RW; i++) begin
      x_src1[i] = cur[s1[i]];  // Sources read before the slot's own write
      x_src2[i] = cur[s2[i]];
      if (sv[i] && dv[i]) begin
        x_old[i] = cur[da[i]];
        x_dest[i] = (k < fq.size()) ? fq[k] : '0;
        cur[da[i]] = x_dest[i];
        k++;
      end else begin
        x_old[i] = '0;
        x_dest[i] = '0;
      end
    end
  endfunction

  task automatic reset_model();
    for (int a = 0; a < NA; a++) begin
      m_map[a] = PW'(a);  // Identity
    end
    m_free.delete();
    for (int r = NA; r < regfile_pkg::NUM_PHYS_REGS; r++) begin
      m_free.push_back(PW'(r));
    end
    retire_q.delete();
  endtask

  // Accepted group takes registers from the model queue head
  task automatic apply_group();
    for (int i = 0; i < RW; i++) begin
      if (slot_valid[i] && dest_valid[i]) begin
        retire_q.push_back(e_old[i]);  // Freed once this writer retires
        m_map[dest_arch[i]] = m_free.pop_front();
      end
    end
  endtask

  task automatic append_frees();
    for (int p = 0; p < FW; p++) begin
      if (free_valid[p]) begin
        m_free.push_back(free_phys[p]);  // Port order, lowest first
      end
    end
  endtask

  task automatic compare_field(input string name, input int slot,
                               input logic [PW-1:0] exp, input logic [PW-1:0] got);
    if (got !== exp) begin
      $display("** Error %s[%0d]: expected %h, got %h", name, slot, exp, got);
      err_cnt++;
    end else begin
      pass_cnt++;
    end
  endtask

  // Compare process
  // Checks a quarter period before each rising edge, then advances the model
  initial begin
    forever begin
      @(negedge clk);
      #(CLK_PERIOD / 4);
      if (check_en) begin
        model_rename(slot_valid, dest_valid, dest_arch, src1_arch, src2_arch, m_map, m_free,
                     e_dest, e_old, e_src1, e_src2, e_stall);
        if (stall !== e_stall) begin
          $display("** Error stall: expected %h, got %h", e_stall, stall);
          err_cnt++;
        end else begin
          pass_cnt++;
        end
        if (!e_stall) begin  // Rename outputs only mean something on acceptance
          for (int i = 0; i < RW; i++) begin
            compare_field("dest_phys", i, e_dest[i], dest_phys[i]);
            compare_field("old_phys", i, e_old[i], old_phys[i]);
            compare_field("src1_phys", i, e_src1[i], src1_phys[i]);
            compare_field("src2_phys", i, e_src2[i], src2_phys[i]);
          end
        end
      end
      @(posedge clk);
      if (check_en) begin
        last_accepted = !e_stall;
        if (!e_stall) begin
          apply_group();
        end
        append_frees();  // Frees land every cycle behind the allocation
      end
    end
  end

  task automatic next_cycle();
    @(negedge clk);
  endtask

  task automatic drive_slot(input int i, input logic sv, input logic dv,
                            input int d, input int a, input int b);
    slot_valid[i] = sv;
    dest_valid[i] = dv;
    dest_arch[i]  = AW'(d);
    src1_arch[i]  = AW'(a);
    src2_arch[i]  = AW'(b);
  endtask

  task automatic idle_group();
    slot_valid = '0;
    dest_valid = '0;
    dest_arch  = '0;
    src1_arch  = '0;
    src2_arch  = '0;
  endtask

  task automatic clear_frees();
    free_valid = '0;
    free_phys  = '0;
  endtask

  task automatic random_group();
    logic [31:0] r;
    for (int i = 0; i < RW; i++) begin
      r = $random(seed);
      slot_valid[i] = (r[1:0] != 2'b00);
      dest_valid[i] = (r[3:2] != 2'b00);
      dest_arch[i]  = r[4] ? r[9:5] : {2'b00, r[7:5]};  // Small range breeds dependencies
      src1_arch[i]  = r[10] ? r[15:11] : {2'b00, r[13:11]};
      src2_arch[i]  = r[16] ? r[21:17] : {2'b00, r[19:17]};
    end
  endtask

  // Sparse frees let the queue drain and stall
  task automatic random_frees(input logic dense);
    logic [31:0] r;
    r = $random(seed);
    for (int p = 0; p < FW; p++) begin
      if (r[p] && (dense || r[p+8]) && (retire_q.size() > 0)) begin
        free_valid[p] = 1'b1;
        free_phys[p]  = retire_q.pop_front();
      end else begin
        free_valid[p] = 1'b0;
        free_phys[p]  = '0;
      end
    end
  endtask

  task automatic end_test(input string name);
    test_num++;
    $display("Test %0d %s: %0d errors", test_num, name, err_cnt - err_base);
    err_base = err_cnt;
  endtask

  // Stimulus on the falling edge
  initial begin
    seed = 32'hb7c4_9060;
    rst = 1'b1;
    check_en = 1'b0;
    last_accepted = 1'b1;
    err_cnt = 0;
    pass_cnt = 0;
    err_base = 0;
    test_num = 0;
    idle_group();
    clear_frees();
    reset_model();
    repeat (10) @(posedge clk);  // Ten reset edges
    next_cycle();
    rst = 1'b0;
    check_en = 1'b1;

    // Identity map and first four free registers
    drive_slot(0, 1'b1, 1'b1, 3, 0, 1);
    drive_slot(1, 1'b1, 1'b1, 7, 2, 4);
    drive_slot(2, 1'b1, 1'b1, 12, 30, 31);
    drive_slot(3, 1'b1, 1'b1, 20, 15, 16);
    next_cycle();
    idle_group();
    next_cycle();
    end_test("after reset");

    // Chains through r5 and r9 inside one group
    drive_slot(0, 1'b1, 1'b1, 5, 1, 2);
    drive_slot(1, 1'b1, 1'b1, 5, 5, 3);
    drive_slot(2, 1'b1, 1'b1, 9, 3, 5);
    drive_slot(3, 1'b1, 1'b1, 10, 9, 9);
    next_cycle();
    idle_group();
    drive_slot(0, 1'b1, 1'b0, 0, 5, 9);  // Sees the last writers
    drive_slot(1, 1'b1, 1'b1, 5, 10, 5);
    next_cycle();
    idle_group();
    next_cycle();
    end_test("in-group dependencies");

    drive_slot(0, 1'b1, 1'b1, 6, 6, 8);
    drive_slot(1, 1'b0, 1'b1, 8, 1, 1);  // Invalid slot gets no register
    drive_slot(2, 1'b1, 1'b0, 11, 6, 2);
    drive_slot(3, 1'b1, 1'b1, 6, 6, 11);
    next_cycle();
    idle_group();
    drive_slot(1, 1'b1, 1'b1, 2, 1, 6);
    drive_slot(2, 1'b1, 1'b1, 2, 2, 4);
    next_cycle();
    idle_group();
    next_cycle();
    end_test("sparse groups");

    // Full groups without frees until the queue runs short
    random_group();
    slot_valid = '1;
    dest_valid = '1;
    next_cycle();
    cycles = 0;
    while (!stall && (cycles < 20)) begin
      random_group();
      slot_valid = '1;
      dest_valid = '1;
      next_cycle();
      cycles++;
    end
    if (!stall) begin
      $display("Timeout: stall did not rise while the free list drained");
      err_cnt++;
    end
    repeat (3) next_cycle();  // Decode holds the group
    end_test("exhaustion");

    // Four frees on scattered ports while the group is held
    free_valid = 6'b111010;
    for (int p = 0; p < FW; p++) begin
      if (free_valid[p]) begin
        free_phys[p] = retire_q.pop_front();
      end
    end
    next_cycle();
    clear_frees();
    cycles = 0;
    while (stall && (cycles < 5)) begin
      next_cycle();
      cycles++;
    end
    if (stall) begin
      $display("Timeout: stall stayed high after registers were freed");
      err_cnt++;
    end
    next_cycle();  // Held group goes through
    idle_group();
    next_cycle();
    end_test("freeing");

    for (int c = 0; c < 300; c++) begin
      if (last_accepted) begin
        random_group();
      end
      random_frees(c >= 150);
      next_cycle();
    end
    idle_group();
    clear_frees();
    next_cycle();
    end_test("random run");

    check_en = 1'b0;
    $display("Checks passed %0d, errors %0d", pass_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: design/free_list.sv
module free_list (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic [width_pkg::ALLOC_CNT_BITS-1:0]       alloc_count,  // Writers in current group
  input  logic [width_pkg::FREE_WIDTH-1:0]           free_valid,
  input  logic [width_pkg::FREE_WIDTH-1:0][regfile_pkg::PREG_BITS-1:0]
                                                     free_phys,    // Retired registers
  output logic [width_pkg::RENAME_WIDTH-1:0][regfile_pkg::PREG_BITS-1:0]
                                                     cand_phys,    // Next four in queue order
  output logic                                       cand_ok       // Enough for a full group
);

  // Queue storage, one physical index per entry
  logic [regfile_pkg::PREG_BITS-1:0] fl_mem [regfile_pkg::NUM_PHYS_REGS];

  logic [regfile_pkg::PREG_BITS-1:0]   head;   // Oldest free entry
  logic [regfile_pkg::PREG_BITS-1:0]   tail;   // Next slot to fill
  logic [regfile_pkg::FL_CNT_BITS-1:0] count;  // Tells full from empty

  logic [width_pkg::FREE_WIDTH-1:0][width_pkg::FREE_CNT_BITS-1:0] free_ofs;  // Prefix count
  logic [width_pkg::FREE_WIDTH-1:0][regfile_pkg::PREG_BITS-1:0]   wr_idx;    // Tail slot per port
  logic [width_pkg::FREE_CNT_BITS-1:0]  free_total;
  logic [width_pkg::ALLOC_CNT_BITS-1:0] take;  // Registers leaving this edge
  logic [regfile_pkg::FL_CNT_BITS-1:0]  count_next;

  // Head window
  // Depends on registered state only
  always_comb begin
    logic [regfile_pkg::PREG_BITS-1:0] rd_idx;
    for (int i = 0; i < width_pkg::RENAME_WIDTH; i++) begin
      rd_idx = head + i[regfile_pkg::PREG_BITS-1:0];  // Wraps with the queue
      cand_phys[i] = fl_mem[rd_idx];
    end
  end

  assign cand_ok = (count >= regfile_pkg::FL_CNT_BITS'(width_pkg::RENAME_WIDTH));

  // Nothing leaves while the group is held
  assign take = cand_ok ? alloc_count : '0;

  // Compact the valid frees
  // Each port lands behind the valid ports below it
  always_comb begin
    free_total = '0;
    for (int p = 0; p < width_pkg::FREE_WIDTH; p++) begin
      free_ofs[p] = free_total;
      wr_idx[p] = tail + {{(regfile_pkg::PREG_BITS - width_pkg::FREE_CNT_BITS){1'b0}},
                          free_ofs[p]};
      free_total = free_total + {{(width_pkg::FREE_CNT_BITS - 1){1'b0}}, free_valid[p]};
    end
  end

  // Occupancy after this edge
  assign count_next = count
                    - {{(regfile_pkg::FL_CNT_BITS - width_pkg::ALLOC_CNT_BITS){1'b0}}, take}
                    + {{(regfile_pkg::FL_CNT_BITS - width_pkg::FREE_CNT_BITS){1'b0}},
                       free_total};

  // Pointers and occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      head  <= '0;
      tail  <= regfile_pkg::FL_RESET_COUNT[regfile_pkg::PREG_BITS-1:0];  // 32 mod 64
      count <= regfile_pkg::FL_RESET_COUNT;
    end else begin
      head  <= head + {{(regfile_pkg::PREG_BITS - width_pkg::ALLOC_CNT_BITS){1'b0}}, take};
      tail  <= tail + {{(regfile_pkg::PREG_BITS - width_pkg::FREE_CNT_BITS){1'b0}},
                       free_total};
      count <= count_next;
    end
  end

  // Queue contents
  // Reset loads the registers not covered by the identity map
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < regfile_pkg::NUM_PHYS_REGS - regfile_pkg::NUM_ARCH_REGS; i++) begin
        fl_mem[i] <= regfile_pkg::FIRST_FREE_PREG + i[regfile_pkg::PREG_BITS-1:0];
      end
    end else begin
      for (int p = 0; p < width_pkg::FREE_WIDTH; p++) begin
        if (free_valid[p]) begin
          fl_mem[wr_idx[p]] <= free_phys[p];  // Never overlaps a live free entry
        end
      end
    end
  end

endmodule

// File: design/regfile_pkg.sv
package regfile_pkg;

  // Register file sizes
  localparam int NUM_PHYS_REGS = 64;
  localparam int NUM_ARCH_REGS = 32;

  localparam int PREG_BITS = $clog2(NUM_PHYS_REGS);  // Physical index width
  localparam int AREG_BITS = $clog2(NUM_ARCH_REGS);  // Architectural index width

  // Free list occupancy runs 0 to NUM_PHYS_REGS inclusive
  localparam int FL_CNT_BITS = PREG_BITS + 1;

  // Registers above the identity map start out free
  localparam logic [FL_CNT_BITS-1:0] FL_RESET_COUNT =
    FL_CNT_BITS'(NUM_PHYS_REGS - NUM_ARCH_REGS);
  localparam logic [PREG_BITS-1:0] FIRST_FREE_PREG = PREG_BITS'(NUM_ARCH_REGS);

endpackage

// File: design/rename_map.sv
module rename_map (
  input  logic                                        clk,
  input  logic                                        rst,
  input  logic [width_pkg::RENAME_WIDTH-1:0]          slot_valid,
  input  logic [width_pkg::RENAME_WIDTH-1:0]          dest_valid,  // Slot writes a register
  input  logic [width_pkg::RENAME_WIDTH-1:0][regfile_pkg::AREG_BITS-1:0]
                                                      dest_arch,
  input  logic [width_pkg::RENAME_WIDTH-1:0][regfile_pkg::AREG_BITS-1:0]
                                                      src1_arch,
  input  logic [width_pkg::RENAME_WIDTH-1:0][regfile_pkg::AREG_BITS-1:0]
                                                      src2_arch,
  input  logic [width_pkg::RENAME_WIDTH-1:0][regfile_pkg::PREG_BITS-1:0]
                                                      cand_phys,   // From free list head
  input  logic                                        cand_ok,
  output logic [width_pkg::RENAME_WIDTH-1:0][regfile_pkg::PREG_BITS-1:0]
                                                      dest_phys,
  output logic [width_pkg::RENAME_WIDTH-1:0][regfile_pkg::PREG_BITS-1:0]
                                                      old_phys,    // Mapping being replaced
  output logic [width_pkg::RENAME_WIDTH-1:0][regfile_pkg::PREG_BITS-1:0]
                                                      src1_phys,
  output logic [width_pkg::RENAME_WIDTH-1:0][regfile_pkg::PREG_BITS-1:0]
                                                      src2_phys,
  output logic [width_pkg::ALLOC_CNT_BITS-1:0]        alloc_count,
  output logic                                        stall
);

  // Architectural to physical table
  logic [regfile_pkg::PREG_BITS-1:0] map_table [regfile_pkg::NUM_ARCH_REGS];

  logic [width_pkg::RENAME_WIDTH-1:0] writes;  // Valid slot with a destination
  logic [width_pkg::RENAME_WIDTH-1:0][width_pkg::ALLOC_CNT_BITS-1:0] wr_before;
  logic [width_pkg::RENAME_WIDTH-1:0][regfile_pkg::PREG_BITS-1:0]    new_phys;

  // The only place slot and destination validity meet
  assign writes = slot_valid & dest_valid;

  // Fewer than four free means the whole group waits
  assign stall = ~cand_ok;

  // Allocation steering
  // The k-th writer in the group takes candidate k
  always_comb begin
    alloc_count = '0;
    for (int i = 0; i < width_pkg::RENAME_WIDTH; i++) begin
      wr_before[i] = alloc_count;  // Writers ahead of slot i
      new_phys[i]  = cand_phys[wr_before[i][width_pkg::SLOT_IDX_BITS-1:0]];
      alloc_count  = alloc_count
                   + {{(width_pkg::ALLOC_CNT_BITS - 1){1'b0}}, writes[i]};
    end
  end

  // Destination outputs
  always_comb begin
    for (int i = 0; i < width_pkg::RENAME_WIDTH; i++) begin
      dest_phys[i] = writes[i] ? new_phys[i] : '0;  // Zero for non-writers
    end
  end

  // Source lookup
  // Table first, then the nearest earlier writer of the group
  always_comb begin
    for (int i = 0; i < width_pkg::RENAME_WIDTH; i++) begin
      src1_phys[i] = map_table[src1_arch[i]];
      src2_phys[i] = map_table[src2_arch[i]];
      for (int j = 0; j < i; j++) begin  // Later j wins so the closest producer sticks
        if (writes[j] && (dest_arch[j] == src1_arch[i])) begin
          src1_phys[i] = new_phys[j];
        end
        if (writes[j] && (dest_arch[j] == src2_arch[i])) begin
          src2_phys[i] = new_phys[j];
        end
      end
    end
  end

  // Previous mapping of each destination
  // An earlier writer of the same register in the group supplies it
  always_comb begin
    for (int i = 0; i < width_pkg::RENAME_WIDTH; i++) begin
      old_phys[i] = map_table[dest_arch[i]];
      for (int j = 0; j < i; j++) begin
        if (writes[j] && (dest_arch[j] == dest_arch[i])) begin
          old_phys[i] = new_phys[j];  // Freed when slot i retires
        end
      end
      if (!writes[i]) begin
        old_phys[i] = '0;
      end
    end
  end

  // Table update on an accepted group
  // Slots run in program order so the last writer lands last
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int a = 0; a < regfile_pkg::NUM_ARCH_REGS; a++) begin
        map_table[a] <= a[regfile_pkg::PREG_BITS-1:0];  // Identity
      end
    end else if (!stall) begin
      for (int j = 0; j < width_pkg::RENAME_WIDTH; j++) begin
        if (writes[j]) begin
          map_table[dest_arch[j]] <= new_phys[j];
        end
      end
    end
  end

endmodule

// File: design/rename_top.sv
module rename_top (
  input  logic                                       clk,
  input  logic                                       rst,
  // Decode side
  input  logic [width_pkg::RENAME_WIDTH-1:0]         slot_valid,
  input  logic [width_pkg::RENAME_WIDTH-1:0]         dest_valid,
  input  logic [width_pkg::RENAME_WIDTH-1:0][regfile_pkg::AREG_BITS-1:0]
                                                     dest_arch,
  input  logic [width_pkg::RENAME_WIDTH-1:0][regfile_pkg::AREG_BITS-1:0]
                                                     src1_arch,
  input  logic [width_pkg::RENAME_WIDTH-1:0][regfile_pkg::AREG_BITS-1:0]
                                                     src2_arch,
  // Commit side
  input  logic [width_pkg::FREE_WIDTH-1:0]           free_valid,
  input  logic [width_pkg::FREE_WIDTH-1:0][regfile_pkg::PREG_BITS-1:0]
                                                     free_phys,
  // Renamed group in the same cycle
  output logic [width_pkg::RENAME_WIDTH-1:0][regfile_pkg::PREG_BITS-1:0]
                                                     dest_phys,
  output logic [width_pkg::RENAME_WIDTH-1:0][regfile_pkg::PREG_BITS-1:0]
                                                     old_phys,
  output logic [width_pkg::RENAME_WIDTH-1:0][regfile_pkg::PREG_BITS-1:0]
                                                     src1_phys,
  output logic [width_pkg::RENAME_WIDTH-1:0][regfile_pkg::PREG_BITS-1:0]
                                                     src2_phys,
  output logic                                       stall   // Decode holds the group
);

  logic [width_pkg::RENAME_WIDTH-1:0][regfile_pkg::PREG_BITS-1:0] cand_phys;
  logic                                  cand_ok;
  logic [width_pkg::ALLOC_CNT_BITS-1:0]  alloc_count;  // Free list sees only the count

  rename_map u_rename_map (
    .clk         (clk),
    .rst         (rst),
    .slot_valid  (slot_valid),
    .dest_valid  (dest_valid),
    .dest_arch   (dest_arch),
    .src1_arch   (src1_arch),
    .src2_arch   (src2_arch),
    .cand_phys   (cand_phys),
    .cand_ok     (cand_ok),
    .dest_phys   (dest_phys),
    .old_phys    (old_phys),
    .src1_phys   (src1_phys),
    .src2_phys   (src2_phys),
    .alloc_count (alloc_count),
    .stall       (stall)
  );

  // Frees go straight in every cycle
  free_list u_free_list (
    .clk         (clk),
    .rst         (rst),
    .alloc_count (alloc_count),
    .free_valid  (free_valid),
    .free_phys   (free_phys),
    .cand_phys   (cand_phys),
    .cand_ok     (cand_ok)
  );

endmodule

// File: design/width_pkg.sv
package width_pkg;

  localparam int RENAME_WIDTH = 4;  // Slots per rename group
  localparam int FREE_WIDTH = 6;    // Commit free ports

  // Count of writing slots from 0 to RENAME_WIDTH
  localparam int ALLOC_CNT_BITS = $clog2(RENAME_WIDTH + 1);
  localparam int SLOT_IDX_BITS = $clog2(RENAME_WIDTH);  // Selects one candidate

  // Count of valid frees from 0 to FREE_WIDTH
  localparam int FREE_CNT_BITS = $clog2(FREE_WIDTH + 1);

endpackage

// File: run.sh
#!/bin/sh
# Compile and run the rename stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_rename_top -f vlog.f
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

./obj_dir/Vtb_rename_top > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# Verdict comes from the log
if grep -q ">>> FAIL" sim.log; then
  echo "Testbench reported failure"
  exit 1
fi

exit 0

// File: vlog.f
design/regfile_pkg.sv
design/width_pkg.sv
design/free_list.sv
design/rename_map.sv
design/rename_top.sv
bench/tb_rename_top.sv
